// ==== source/qv_mem_pkg.sv ====
/* Instruction memory port definitions
   Address width, halfword and address types,
   request and response structs of the fetch port
 */

package qv_mem_pkg;

    localparam int ADDR_BITS = 24;  // Byte address width of instruction memory

    // One instruction halfword as delivered by memory
    typedef logic [15:0] hword_t;

    // Halfword address, bit 0 of the byte address is always zero
    typedef logic [ADDR_BITS-1:1] haddr_t;

    // Request towards instruction memory
    typedef struct packed {
        haddr_t addr;     // Burst start / next halfword address
        logic   restart;  // Level, memory may begin a burst at addr
        logic   stall;    // Level, buffer cannot take another halfword
    } fetch_req_t;

    // Response from instruction memory
    typedef struct packed {
        logic   started;  // Pulse when a burst begins
        logic   stopped;  // Pulse when a burst ends
        logic   ready;    // Pulse per delivered halfword
        hword_t data;
    } fetch_resp_t;

endpackage

// ==== source/qv_instr_pkg.sv ====
/* Instruction definitions
   Instruction class enum, decoded instruction struct
   and the RV32I major opcodes
 */

package qv_instr_pkg;

    typedef enum logic [3:0] {
        ic_load,
        ic_store,
        ic_alu_imm,
        ic_alu_reg,
        ic_lui,
        ic_auipc,
        ic_branch,
        ic_jal,
        ic_jalr,
        ic_system,
        ic_compressed,
        ic_illegal
    } iclass_t;

    // Issued instruction, register indices cut to 4 bits as in RV32E
    typedef struct packed {
        qv_mem_pkg::haddr_t pc;
        logic               is_32;   // Two halfwords long
        iclass_t            iclass;
        logic [2:0]         funct3;
        logic [3:0]         rd;
        logic [3:0]         rs1;
        logic [3:0]         rs2;
        logic [31:0]        imm;     // Sign extended
    } decoded_t;

    // RV32I major opcodes
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_system  = 7'b1110011;

endpackage

// ==== source/qv_fetch_ctrl.sv ====
/* Fetch controller
   Next fetch address, burst running state and
   generation of the restart level towards memory
 */

module qv_fetch_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    redirect,
    input  qv_mem_pkg::haddr_t      redirect_addr,
    input  qv_mem_pkg::fetch_resp_t resp,
    output qv_mem_pkg::haddr_t      addr,
    output logic                    restart,
    output logic                    hw_wr
);
    import qv_mem_pkg::*;

    logic   running;       // A burst is in progress
    logic   running_next;
    logic   restart_q;
    haddr_t addr_next;

    // Halfwords only count while a burst is running
    assign hw_wr = resp.ready && running;

    always_comb begin
        running_next = running;
        if (redirect) begin
            running_next = 1'b0;  // Abandon the current burst
        end else if (resp.started) begin
            running_next = 1'b1;
        end else if (resp.stopped) begin
            running_next = 1'b0;
        end
    end

    always_comb begin
        addr_next = addr;
        if (redirect) begin
            addr_next = redirect_addr;
        end else if (hw_wr) begin
            addr_next = addr + haddr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            running   <= 1'b0;
            restart_q <= 1'b0;
            addr      <= '0;
        end else begin
            running   <= running_next;
            restart_q <= !running_next;
            addr      <= addr_next;
        end
    end

    /* Restart follows the idle state, so after a stall ends a burst the
       memory picks up again at the halfword after the last one taken.
       It drops for the redirect cycle itself. */
    assign restart = restart_q && !redirect;

endmodule

// ==== source/qv_instr_buffer.sv ====
/* Instruction halfword buffer
   Four entry ring with fill count, one or two
   halfword pop, flush and look-ahead full flag
 */

module qv_instr_buffer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               flush,
    input  logic               wr,
    input  qv_mem_pkg::hword_t wr_data,
    input  logic               pop,
    input  logic               pop_two,
    output qv_mem_pkg::hword_t head_lo,
    output qv_mem_pkg::hword_t head_hi,
    output logic [2:0]         count,
    output logic               full
);
    import qv_mem_pkg::*;

    hword_t     mem [4];
    logic [1:0] rd_ptr;
    logic [1:0] rd_ptr_hi;
    logic [1:0] wr_ptr;
    logic [1:0] pop_len;

    assign pop_len = pop ? (pop_two ? 2'd2 : 2'd1) : 2'd0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;  // Drop everything, pending write included
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + pop_len;
            wr_ptr <= wr_ptr + {1'b0, wr};
            count  <= count + {2'b00, wr} - {1'b0, pop_len};
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // 32-bit window at the head, may wrap around the ring
    assign rd_ptr_hi = rd_ptr + 2'd1;
    assign head_lo   = mem[rd_ptr];
    assign head_hi   = mem[rd_ptr_hi];

    // Also full when the last free slot is being written now without a pop
    assign full = (count == 3'd4) || (count == 3'd3 && wr && !pop);

endmodule

// ==== source/qv_decoder.sv ====
/* Instruction decoder
   Combinational RV32 decode of the 32-bit window at the buffer head,
   class, register fields and immediate, no pc
 */

module qv_decoder (
    input  logic [31:0]            window,
    output qv_instr_pkg::decoded_t dec
);
    import qv_instr_pkg::*;

    logic        is_32;
    logic [6:0]  opcode;
    logic [4:0]  rd_f;
    logic [4:0]  rs1_f;
    logic [4:0]  rs2_f;
    logic        use_rd;
    logic        use_rs1;
    logic        use_rs2;
    logic        bad_reg;
    iclass_t     cls;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign is_32  = window[1:0] == 2'b11;
    assign opcode = window[6:0];
    assign rd_f   = window[11:7];
    assign rs1_f  = window[19:15];
    assign rs2_f  = window[24:20];

    assign imm_i = {{20{window[31]}}, window[31:20]};
    assign imm_s = {{20{window[31]}}, window[31:25], window[11:7]};
    assign imm_b = {{19{window[31]}}, window[31], window[7], window[30:25], window[11:8], 1'b0};
    assign imm_u = {window[31:12], 12'h000};
    assign imm_j = {{11{window[31]}}, window[31], window[19:12], window[20], window[30:21], 1'b0};

    // Opcode to class
    always_comb begin
        case (opcode)
            op_load:    cls = ic_load;
            op_store:   cls = ic_store;
            op_alu_imm: cls = ic_alu_imm;
            op_alu_reg: cls = ic_alu_reg;
            op_lui:     cls = ic_lui;
            op_auipc:   cls = ic_auipc;
            op_branch:  cls = ic_branch;
            op_jal:     cls = ic_jal;
            op_jalr:    cls = ic_jalr;
            op_system:  cls = ic_system;
            default:    cls = ic_illegal;
        endcase
    end

    // Register fields that each class reads or writes
    assign use_rd  = cls inside {ic_load, ic_alu_imm, ic_alu_reg, ic_lui, ic_auipc,
                                 ic_jal, ic_jalr, ic_system};
    assign use_rs1 = cls inside {ic_load, ic_store, ic_alu_imm, ic_alu_reg, ic_branch,
                                 ic_jalr, ic_system};
    assign use_rs2 = cls inside {ic_store, ic_alu_reg, ic_branch};

    // Only 16 registers exist
    assign bad_reg = (use_rd && rd_f[4]) || (use_rs1 && rs1_f[4]) || (use_rs2 && rs2_f[4]);

    always_comb begin
        dec       = '0;
        dec.is_32 = is_32;
        if (!is_32) begin
            dec.iclass = ic_compressed;  // Length only and no fields
        end else if (cls == ic_illegal || bad_reg) begin
            dec.iclass = ic_illegal;
        end else begin
            dec.iclass = cls;
            dec.funct3 = use_rs1 ? window[14:12] : 3'b000;  // U and J formats have none
            dec.rd     = use_rd  ? rd_f[3:0]  : 4'h0;
            dec.rs1    = use_rs1 ? rs1_f[3:0] : 4'h0;
            dec.rs2    = use_rs2 ? rs2_f[3:0] : 4'h0;
            case (cls)
                ic_store:           dec.imm = imm_s;
                ic_branch:          dec.imm = imm_b;
                ic_lui, ic_auipc:   dec.imm = imm_u;
                ic_jal:             dec.imm = imm_j;
                ic_alu_reg:         dec.imm = 32'h0;
                default:            dec.imm = imm_i;
            endcase
        end
    end

endmodule

// ==== source/qv_issue.sv ====
/* Issue stage
   Program counter, registered instruction for the core
   and the pop decision towards the buffer
 */

module qv_issue (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   redirect,
    input  qv_mem_pkg::haddr_t     redirect_addr,
    input  logic                   instr_complete,
    input  qv_mem_pkg::hword_t     head_lo,
    input  qv_mem_pkg::hword_t     head_hi,
    input  logic [2:0]             count,
    output logic                   pop,
    output logic                   pop_two,
    output qv_instr_pkg::decoded_t instr,
    output logic                   instr_valid
);
    import qv_mem_pkg::*;
    import qv_instr_pkg::*;

    decoded_t dec;
    decoded_t issued;
    haddr_t   pc;
    logic     fits;   // Whole instruction is in the buffer
    logic     take;   // Issue register can be reloaded
    logic     load;

    qv_decoder decoder_i (
        .window ({head_hi, head_lo}),
        .dec    (dec)
    );

    // count is checked first so an empty buffer never looks at stale data
    assign fits = (count >= 3'd2) || (count == 3'd1 && !dec.is_32);
    assign take = !instr_valid || instr_complete;
    assign load = take && fits && !redirect;

    assign pop     = load;
    assign pop_two = dec.is_32;

    always_comb begin
        issued    = dec;
        issued.pc = pc;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            instr_valid <= 1'b0;
            pc          <= '0;
        end else if (redirect) begin
            instr_valid <= 1'b0;      // Overrides a completion in the same cycle
            pc          <= redirect_addr;
        end else if (take) begin
            instr_valid <= fits;
            if (fits) pc <= pc + (dec.is_32 ? haddr_t'(2) : haddr_t'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            instr <= issued;
        end
    end

endmodule

// ==== source/qv_fetch_top.sv ====
/* Instruction front end top level
   Fetch controller, halfword buffer and issue stage,
   memory request packing
 */

module qv_fetch_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  qv_mem_pkg::fetch_resp_t mem_resp,
    input  logic                    redirect,
    input  qv_mem_pkg::haddr_t      redirect_addr,
    input  logic                    instr_complete,
    output qv_mem_pkg::fetch_req_t  mem_req,
    output qv_instr_pkg::decoded_t  instr,
    output logic                    instr_valid
);
    import qv_mem_pkg::*;

    haddr_t     fetch_addr;
    logic       fetch_restart;
    logic       hw_wr;
    hword_t     head_lo;
    hword_t     head_hi;
    logic [2:0] buf_count;
    logic       buf_full;
    logic       pop;
    logic       pop_two;

    qv_fetch_ctrl fetch_i (
        .clk           (clk),
        .rstn          (rstn),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .resp          (mem_resp),
        .addr          (fetch_addr),
        .restart       (fetch_restart),
        .hw_wr         (hw_wr)
    );

    qv_instr_buffer buffer_i (
        .clk     (clk),
        .rstn    (rstn),
        .flush   (redirect),
        .wr      (hw_wr),
        .wr_data (mem_resp.data),
        .pop     (pop),
        .pop_two (pop_two),
        .head_lo (head_lo),
        .head_hi (head_hi),
        .count   (buf_count),
        .full    (buf_full)
    );

    qv_issue issue_i (
        .clk            (clk),
        .rstn           (rstn),
        .redirect       (redirect),
        .redirect_addr  (redirect_addr),
        .instr_complete (instr_complete),
        .head_lo        (head_lo),
        .head_hi        (head_hi),
        .count          (buf_count),
        .pop            (pop),
        .pop_two        (pop_two),
        .instr          (instr),
        .instr_valid    (instr_valid)
    );

    assign mem_req = '{addr: fetch_addr, restart: fetch_restart, stall: buf_full};

endmodule

// ==== verif/qv_fetch_assert.sv ====
/* Bound assertions
   Buffer fill limit, no write into a full buffer,
   restart after a redirect
 */

module qv_fetch_assert (
    input logic       clk,
    input logic       rstn,
    input logic [2:0] count,
    input logic       wr,
    input logic       redirect,
    input logic       restart
);

    count_limit: assert property (@(posedge clk) disable iff (!rstn) count <= 3'd4)
        else $error("buffer count above four");

    // Memory has seen stall before the count reaches four
    write_when_full: assert property (@(posedge clk) disable iff (!rstn) wr |-> count != 3'd4)
        else $error("halfword written into a full buffer");

    restart_after_redirect: assert property (@(posedge clk) disable iff (!rstn)
        redirect |=> restart)
        else $error("restart low after a redirect");

endmodule

bind qv_instr_buffer qv_fetch_assert buffer_chk (
    .clk      (clk),
    .rstn     (rstn),
    .count    (count),
    .wr       (wr),
    .redirect (1'b0),
    .restart  (1'b0)
);

bind qv_fetch_ctrl qv_fetch_assert fetch_chk (
    .clk      (clk),
    .rstn     (rstn),
    .count    (3'd0),
    .wr       (1'b0),
    .redirect (redirect),
    .restart  (restart)
);

// ==== verif/qv_fetch_tb.sv ====
/* Front end testbench
   Instruction memory model with random delays, stimulus table,
   completion and redirect driver, field checks
 */

module qv_fetch_tb;
    import qv_mem_pkg::*;
    import qv_instr_pkg::*;

    typedef struct packed {
        haddr_t      pc;
        iclass_t     iclass;
        logic [2:0]  funct3;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [31:0] imm;
        int          hold;        // Cycles the core holds off completion
        logic        redir;
        haddr_t      redir_addr;
    } row_t;

    logic        clk;
    logic        rstn;
    fetch_resp_t mem_resp;
    logic        redirect;
    haddr_t      redirect_addr;
    logic        instr_complete;
    fetch_req_t  mem_req;
    decoded_t    instr;
    logic        instr_valid;

    logic [15:0] image [256];
    row_t        rows [$];
    logic [31:0] rnd = 32'hcb95;
    logic        bursting;
    logic        started_last;
    haddr_t      baddr;
    logic        stall_seen;
    int          stop_count;
    int          errors;
    int          timeouts;

    qv_fetch_top dut_i (
        .clk            (clk),
        .rstn           (rstn),
        .mem_resp       (mem_resp),
        .redirect       (redirect),
        .redirect_addr  (redirect_addr),
        .instr_complete (instr_complete),
        .mem_req        (mem_req),
        .instr          (instr),
        .instr_valid    (instr_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = !clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic put_word(input int addr, input logic [31:0] word);
        image[addr]     = word[15:0];   // Low halfword first
        image[addr + 1] = word[31:16];
    endtask

    task automatic add_row(input int pc, input iclass_t cls, input int f3, input int rd,
                           input int rs1, input int rs2, input logic [31:0] imm,
                           input int hold, input int raddr);
        row_t r;
        r.pc         = haddr_t'(pc);
        r.iclass     = cls;
        r.funct3     = 3'(f3);
        r.rd         = 4'(rd);
        r.rs1        = 4'(rs1);
        r.rs2        = 4'(rs2);
        r.imm        = imm;
        r.hold       = hold;
        r.redir      = raddr >= 0;
        r.redir_addr = haddr_t'(raddr < 0 ? 0 : raddr);
        rows.push_back(r);
    endtask

    // Memory model decides at the edge and drives 1 unit later
    always @(posedge clk) begin : memory_model
        fetch_req_t  req;
        fetch_resp_t resp;
        req  = mem_req;
        resp = '0;
        rnd  = next_rand(rnd);
        if (!rstn) begin
            bursting = 1'b0;
        end else if (req.restart && !req.stall && !started_last) begin
            bursting = 1'b1;   // New burst that also abandons an old one
            baddr    = req.addr;
            resp.started = 1'b1;
        end else if (bursting && req.stall) begin
            bursting     = 1'b0;
            resp.stopped = 1'b1;
            stop_count++;
        end else if (bursting && rnd[1:0] != 2'b00) begin
            resp.ready = 1'b1;
            resp.data  = image[baddr[8:1]];
            baddr      = baddr + haddr_t'(1);
        end
        if (rstn && req.stall) stall_seen = 1'b1;
        started_last = resp.started;
        #1 mem_resp = resp;
    end

    initial begin : main
        int   n;
        row_t r;
        mem_resp       = '0;
        redirect       = 1'b0;
        redirect_addr  = '0;
        instr_complete = 1'b0;
        rstn           = 1'b0;
        bursting       = 1'b0;
        started_last   = 1'b0;
        baddr          = '0;
        stall_seen     = 1'b0;
        stop_count     = 0;
        errors         = 0;
        timeouts       = 0;

        for (int i = 0; i < 256; i++) image[i] = 16'(i * 257) ^ 16'h5a3c;
        put_word(0, 32'hFFB10093);   // addi x1, x2, -5
        put_word(2, 32'h0051A623);   // sw x5, 12(x3)
        put_word(4, 32'hFE208CE3);   // beq x1, x2, -8
        image[6] = 16'h0001;         // c.nop
        put_word(7, 32'h123453B7);   // lui x7, 0x12345 on an odd halfword
        put_word(9, 32'h010000EF);   // jal x1, 16
        image[11] = 16'h4501;        // c.li
        put_word(12, 32'h00208833);  // add x16, x1, x2
        put_word(14, 32'h0000007F);  // Unknown opcode
        put_word(16, 32'h80032203);  // lw x4, -2048(x6)
        put_word(18, 32'hFFFFF197);  // auipc x3, 0xfffff
        put_word(20, 32'h00428167);  // jalr x2, 4(x5)
        put_word(40, 32'h305211F3);  // csrrw x3, 0x305, x4
        put_word(42, 32'h407302B3);  // sub x5, x6, x7
        image[44] = 16'h8082;        // c.ret

        add_row(0,  ic_alu_imm,    0, 1, 2, 0, 32'hFFFFFFFB, 0,  -1);
        add_row(2,  ic_store,      2, 0, 3, 5, 32'h0000000C, 1,  -1);
        add_row(4,  ic_branch,     0, 0, 1, 2, 32'hFFFFFFF8, 20, -1);
        add_row(6,  ic_compressed, 0, 0, 0, 0, 32'h0,        0,  -1);
        add_row(7,  ic_lui,        0, 7, 0, 0, 32'h12345000, 2,  -1);
        add_row(9,  ic_jal,        0, 1, 0, 0, 32'h00000010, 0,  -1);
        add_row(11, ic_compressed, 0, 0, 0, 0, 32'h0,        1,  -1);
        add_row(12, ic_illegal,    0, 0, 0, 0, 32'h0,        0,  -1);
        add_row(14, ic_illegal,    0, 0, 0, 0, 32'h0,        0,  -1);
        add_row(16, ic_load,       2, 4, 6, 0, 32'hFFFFF800, 30, -1);
        add_row(18, ic_auipc,      0, 3, 0, 0, 32'hFFFFF000, 0,  -1);
        add_row(20, ic_jalr,       0, 2, 5, 0, 32'h00000004, 6,  40);
        add_row(40, ic_system,     1, 3, 4, 0, 32'h00000305, 0,  -1);
        add_row(42, ic_alu_reg,    0, 5, 6, 7, 32'h0,        3,  -1);
        add_row(44, ic_compressed, 0, 0, 0, 0, 32'h0,        0,  -1);

        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;
        @(posedge clk);
        #1;
        compare_value("instr_valid after reset", 32'(instr_valid), 32'd0);
        compare_value("restart after reset", 32'(mem_req.restart), 32'd1);
        compare_value("fetch addr after reset", 32'(mem_req.addr), 32'd0);

        foreach (rows[i]) begin
            r = rows[i];
            n = 0;
            while (!instr_valid && n < 200) begin
                @(posedge clk);
                #1 n++;
            end
            if (!instr_valid) begin
                $display("Timeout: no valid instruction for table row %0d", i);
                timeouts++;
                break;
            end
            compare_value("pc", 32'(instr.pc), 32'(r.pc));
            compare_value("is_32", 32'(instr.is_32), 32'(r.iclass != ic_compressed));
            compare_value("class", 32'(instr.iclass), 32'(r.iclass));
            compare_value("funct3", 32'(instr.funct3), 32'(r.funct3));
            compare_value("rd", 32'(instr.rd), 32'(r.rd));
            compare_value("rs1", 32'(instr.rs1), 32'(r.rs1));
            compare_value("rs2", 32'(instr.rs2), 32'(r.rs2));
            compare_value("imm", instr.imm, r.imm);
            repeat (r.hold) @(posedge clk);
            #1;
            if (r.redir) begin
                redirect      = 1'b1;
                redirect_addr = r.redir_addr;
            end else begin
                instr_complete = 1'b1;
            end
            @(posedge clk);
            #1;
            redirect       = 1'b0;
            instr_complete = 1'b0;
        end

        compare_value("stall seen", 32'(stall_seen), 32'd1);
        compare_value("bursts ended by stall", 32'(stop_count != 0), 32'd1);
        $display("Checks done: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/qv_mem_pkg.sv
source/qv_instr_pkg.sv
source/qv_fetch_ctrl.sv
source/qv_instr_buffer.sv
source/qv_decoder.sv
source/qv_issue.sv
source/qv_fetch_top.sv
verif/qv_fetch_assert.sv
verif/qv_fetch_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = qv_fetch_tb
FLIST     = flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^SIMULATION PASSED$$'

clean:
	rm -rf obj_dir
